// ==== list.f ====
udp_echo_pkg.sv
udp_rx_parser.sv
echo_filter.sv
payload_fifo.sv
udp_tx_builder.sv
udp_echo_top.sv
udp_echo_asserts.sv
tb_udp_echo.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_udp_echo
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_udp_echo.sv ====
`timescale 1ns/10ps

module tb_udp_echo
    import udp_echo_pkg::*;
();

    localparam logic [31:0] SEED          = 32'h54b042b2;
    localparam int          BYTE_TIMEOUT  = 2000;
    localparam int          DRAIN_TIMEOUT = 20000;

    logic       clk;
    logic       rst;
    logic [7:0] in_data;
    logic       in_valid;
    logic       in_last;
    logic       in_ready;
    logic [7:0] out_data;
    logic       out_valid;
    logic       out_last;
    logic       out_ready;

    logic [31:0] pay_lfsr;
    logic [31:0] stall_lfsr;
    logic        stall_on;
    logic        use_stall;
    logic [7:0]  frame_q[$];
    logic [7:0]  exp_data_q[$];
    logic        exp_last_q[$];

    udp_echo_top udp_echo_top_inst (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            pay_lfsr = lfsr_next(pay_lfsr);
            val = {val[30:0], pay_lfsr[0]};
        end
    endtask

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    // ones-complement sum over the ten IP header words
    function automatic logic [15:0] ip_checksum(input logic [15:0] w[10]);
        logic [31:0] sum;
        sum = '0;
        foreach (w[i]) begin
            sum = sum + 32'(w[i]);
        end
        while (sum[31:16] != 16'h0000) begin
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        end
        return ~sum[15:0];
    endfunction

    task automatic push_field(ref logic [7:0] q[$], input logic [47:0] v, input int nbytes);
        for (int i = nbytes - 1; i >= 0; i--) begin
            q.push_back(v[i*8 +: 8]);
        end
    endtask

    // request into frame_q, reply into the expected queues when it must be echoed
    task automatic build_request(input logic [47:0] dst_mac, input logic [15:0] eth_type,
                                 input logic [7:0] proto, input logic [15:0] dst_port,
                                 input int n, input int cut);
        logic [31:0] r;
        logic [47:0] smac;
        logic [31:0] sip;
        logic [15:0] sport;
        logic [15:0] ulen;
        logic [15:0] words[10];
        logic [7:0]  pay[$];
        int          plen;
        int          start;
        bit          echoed;
        random_bits(5, r);
        plen  = int'(r) + 1;
        smac  = {40'h02_aa_bb_cc_dd, 8'(n)};
        sip   = {8'd10, 8'd0, 8'd0, 8'(n)};
        sport = 16'd5000 + 16'(n);
        ulen  = 16'(plen + 8);
        for (int i = 0; i < plen; i++) begin
            random_bits(8, r);
            pay.push_back(r[7:0]);
        end
        frame_q.delete();
        push_field(frame_q, dst_mac, 6);
        push_field(frame_q, smac, 6);
        push_field(frame_q, {eth_type, 16'h4500, 16'(plen + 28)}, 6);
        push_field(frame_q, {32'h0, 8'd64, proto}, 6);
        push_field(frame_q, 48'h0, 2);
        push_field(frame_q, 48'(sip), 4);
        push_field(frame_q, 48'(LOCAL_IP), 4);
        push_field(frame_q, {sport, dst_port, ulen}, 6);
        push_field(frame_q, 48'h0, 2);
        foreach (pay[i]) begin
            frame_q.push_back(pay[i]);
        end
        while (cut > 0 && frame_q.size() > cut) begin
            void'(frame_q.pop_back());
        end
        echoed = (dst_mac == LOCAL_MAC || dst_mac == 48'hffff_ffff_ffff) &&
                 eth_type == 16'h0800 && proto == 8'd17 &&
                 dst_port == ECHO_PORT && cut == 0;
        if (echoed) begin
            words = '{16'h4500, ulen + 16'd20, 16'h0, 16'h0, 16'h4011, 16'h0,
                      LOCAL_IP[31:16], LOCAL_IP[15:0], sip[31:16], sip[15:0]};
            start = exp_data_q.size();
            push_field(exp_data_q, smac, 6);
            push_field(exp_data_q, LOCAL_MAC, 6);
            push_field(exp_data_q, {16'h0800, 16'h4500, ulen + 16'd20}, 6);
            push_field(exp_data_q, {32'h0, 16'h4011}, 6);
            push_field(exp_data_q, {ip_checksum(words), LOCAL_IP}, 6);
            push_field(exp_data_q, {sip, dst_port}, 6);
            push_field(exp_data_q, {sport, ulen, 16'h0000}, 6);
            foreach (pay[i]) begin
                exp_data_q.push_back(pay[i]);
            end
            for (int i = start; i < exp_data_q.size(); i++) begin
                exp_last_q.push_back(i == exp_data_q.size() - 1);
            end
        end
    endtask

    // called 1 ns after a rising edge, returns at the same phase
    task automatic send_frame();
        int waited;
        for (int i = 0; i < frame_q.size(); i++) begin
            in_data  = frame_q[i];
            in_valid = 1'b1;
            in_last  = (i == frame_q.size() - 1);
            waited   = 0;
            @(negedge clk);
            while (!in_ready && waited < BYTE_TIMEOUT) begin
                waited++;
                @(negedge clk);
            end
            if (!in_ready) begin
                $display("timeout waiting for in_ready on byte %0d", i);
                abort_run();
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_data_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_data_q.size() != 0) begin
            $display("timeout with %0d reply bytes still expected", exp_data_q.size());
            abort_run();
        end
        // room for a stray reply to show up
        repeat (100) @(posedge clk);
        #1;
    endtask

    // random stalls on the reply stream
    always @(posedge clk) begin
        use_stall = stall_on;
        #1;
        if (use_stall) begin
            stall_lfsr = lfsr_next(stall_lfsr);
            out_ready  = stall_lfsr[0];
            stall_lfsr = lfsr_next(stall_lfsr);
            out_ready  = out_ready | stall_lfsr[0];
        end else begin
            out_ready = 1'b1;
        end
    end

    // reply bytes are compared where the transfer is stable
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (exp_data_q.size() == 0) begin
                $display("reply byte 0x%h seen while no reply was expected", out_data);
                abort_run();
            end else if (out_ready) begin
                assert (out_data == exp_data_q[0]) else begin
                    $display("ERR out_data got %h expected %h", out_data, exp_data_q[0]);
                    abort_run();
                end
                assert (out_last == exp_last_q[0]) else begin
                    $display("ERR out_last got %h expected %h", out_last, exp_last_q[0]);
                    abort_run();
                end
                void'(exp_data_q.pop_front());
                void'(exp_last_q.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        if (udp_echo_top_inst.udp_echo_asserts_inst.violations != 0) begin
            $display("a bound protocol assertion failed");
            abort_run();
        end
    end

    initial begin
        rst        = 1'b1;
        in_data    = 8'h00;
        in_valid   = 1'b0;
        in_last    = 1'b0;
        out_ready  = 1'b1;
        stall_on   = 1'b0;
        pay_lfsr   = SEED;
        stall_lfsr = SEED;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle after reset
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            assert (in_ready == 1'b1) else begin
                $display("ERR in_ready got %h expected 1", in_ready);
                abort_run();
            end
        end
        @(posedge clk);
        #1;

        // plain echo
        build_request(LOCAL_MAC, 16'h0800, 8'd17, ECHO_PORT, 1, 0);
        send_frame();
        wait_drained();

        // other port dropped, next one still echoed
        build_request(LOCAL_MAC, 16'h0800, 8'd17, 16'd4321, 2, 0);
        send_frame();
        build_request(LOCAL_MAC, 16'h0800, 8'd17, ECHO_PORT, 3, 0);
        send_frame();
        wait_drained();

        // header filter cases, then broadcast
        build_request(48'h02_00_00_00_00_99, 16'h0800, 8'd17, ECHO_PORT, 4, 0);
        send_frame();
        build_request(LOCAL_MAC, 16'h86dd, 8'd17, ECHO_PORT, 5, 0);
        send_frame();
        build_request(LOCAL_MAC, 16'h0800, 8'd6, ECHO_PORT, 6, 0);
        send_frame();
        build_request(LOCAL_MAC, 16'h0800, 8'd17, ECHO_PORT, 7, 20);
        send_frame();
        build_request(48'hffff_ffff_ffff, 16'h0800, 8'd17, ECHO_PORT, 8, 0);
        send_frame();
        wait_drained();

        // reply stalls
        stall_on = 1'b1;
        for (int n = 10; n < 16; n++) begin
            build_request(LOCAL_MAC, 16'h0800, 8'd17, ECHO_PORT, n, 0);
            send_frame();
            wait_drained();
        end

        // back to back, more frames than reply slots
        for (int n = 20; n < 25; n++) begin
            build_request(LOCAL_MAC, 16'h0800, 8'd17, ECHO_PORT, n, 0);
            send_frame();
        end
        wait_drained();

        if (udp_echo_top_inst.udp_echo_asserts_inst.violations == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

// ==== udp_echo_asserts.sv ====
`timescale 1ns/10ps

module udp_echo_asserts (
    input logic       clk,
    input logic       rst,
    input logic       in_ready,
    input logic [7:0] out_data,
    input logic       out_valid,
    input logic       out_last,
    input logic       out_ready
);

    int violations = 0;

    // no reply traffic right after reset
    reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            $error("out_valid high after reset");
            violations++;
        end

    // a stalled byte holds until it is taken
    hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else begin
            $error("reply byte changed while stalled");
            violations++;
        end

    last_with_valid: assert property (@(posedge clk) disable iff (rst)
        out_last |-> out_valid)
        else begin
            $error("out_last without out_valid");
            violations++;
        end

    ready_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(in_ready))
        else begin
            $error("in_ready is unknown");
            violations++;
        end

endmodule

bind udp_echo_top udp_echo_asserts udp_echo_asserts_inst (
    .clk       (clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_ready (out_ready)
);

// ==== udp_echo_top.sv ====
`timescale 1ns/10ps

module udp_echo_top
    import udp_echo_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] in_data,
    input  logic       in_valid,
    input  logic       in_last,
    output logic       in_ready,
    output logic [7:0] out_data,
    output logic       out_valid,
    output logic       out_last,
    input  logic       out_ready
);

    // parser to filter
    logic [7:0] pay_data;
    logic       pay_valid;
    logic       pay_last;
    logic       pay_ready;
    logic       hdr_ok;
    mac_t       src_mac;
    ip_addr_t   src_ip;
    port_t      src_port;
    port_t      dst_port;
    port_t      udp_len;

    // filter to FIFO
    logic [7:0] fifo_in_data;
    logic       fifo_in_last;
    logic       fifo_in_valid;
    logic       fifo_in_ready;

    // FIFO to builder
    logic [7:0] fifo_out_data;
    logic       fifo_out_last;
    logic       fifo_out_valid;
    logic       fifo_out_ready;

    // reply header queue
    logic       q_valid;
    mac_t       q_mac;
    ip_addr_t   q_ip;
    port_t      q_src_port;
    port_t      q_dst_port;
    port_t      q_len;
    logic       q_pop;

    udp_rx_parser udp_rx_parser_inst (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_ready  (in_ready),
        .pay_data  (pay_data),
        .pay_valid (pay_valid),
        .pay_last  (pay_last),
        .pay_ready (pay_ready),
        .hdr_ok    (hdr_ok),
        .src_mac   (src_mac),
        .src_ip    (src_ip),
        .src_port  (src_port),
        .dst_port  (dst_port),
        .udp_len   (udp_len)
    );

    echo_filter echo_filter_inst (
        .clk           (clk),
        .rst           (rst),
        .pay_data      (pay_data),
        .pay_valid     (pay_valid),
        .pay_last      (pay_last),
        .pay_ready     (pay_ready),
        .hdr_ok        (hdr_ok),
        .src_mac       (src_mac),
        .src_ip        (src_ip),
        .src_port      (src_port),
        .dst_port      (dst_port),
        .udp_len       (udp_len),
        .fifo_in_data  (fifo_in_data),
        .fifo_in_last  (fifo_in_last),
        .fifo_in_valid (fifo_in_valid),
        .fifo_in_ready (fifo_in_ready),
        .q_valid       (q_valid),
        .q_mac         (q_mac),
        .q_ip          (q_ip),
        .q_src_port    (q_src_port),
        .q_dst_port    (q_dst_port),
        .q_len         (q_len),
        .q_pop         (q_pop)
    );

    payload_fifo payload_fifo_inst (
        .clk            (clk),
        .rst            (rst),
        .fifo_in_data   (fifo_in_data),
        .fifo_in_last   (fifo_in_last),
        .fifo_in_valid  (fifo_in_valid),
        .fifo_in_ready  (fifo_in_ready),
        .fifo_out_data  (fifo_out_data),
        .fifo_out_last  (fifo_out_last),
        .fifo_out_valid (fifo_out_valid),
        .fifo_out_ready (fifo_out_ready)
    );

    udp_tx_builder udp_tx_builder_inst (
        .clk            (clk),
        .rst            (rst),
        .q_valid        (q_valid),
        .q_mac          (q_mac),
        .q_ip           (q_ip),
        .q_src_port     (q_src_port),
        .q_dst_port     (q_dst_port),
        .q_len          (q_len),
        .q_pop          (q_pop),
        .fifo_out_data  (fifo_out_data),
        .fifo_out_last  (fifo_out_last),
        .fifo_out_valid (fifo_out_valid),
        .fifo_out_ready (fifo_out_ready),
        .out_data       (out_data),
        .out_valid      (out_valid),
        .out_last       (out_last),
        .out_ready      (out_ready)
    );

endmodule

// ==== udp_tx_builder.sv ====
`timescale 1ns/10ps

module udp_tx_builder
    import udp_echo_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       q_valid,
    input  mac_t       q_mac,
    input  ip_addr_t   q_ip,
    input  port_t      q_src_port,
    input  port_t      q_dst_port,
    input  port_t      q_len,
    output logic       q_pop,
    input  logic [7:0] fifo_out_data,
    input  logic       fifo_out_last,
    input  logic       fifo_out_valid,
    output logic       fifo_out_ready,
    output logic [7:0] out_data,
    output logic       out_valid,
    output logic       out_last,
    input  logic       out_ready
);

    logic                     in_hdr;
    logic                     in_pay;
    logic [5:0]               idx;
    logic [HDR_BYTES*8-1:0]   hdr_sr;
    logic [HDR_BYTES*8-1:0]   hdr_next;
    port_t                    ip_total_len;
    logic [19:0]              csum_acc;
    logic [19:0]              csum_fold;
    port_t                    csum_sum;
    port_t                    ip_csum;

    assign q_pop = !in_hdr && !in_pay && q_valid;

    // reply IP header, id/flags/dscp/ecn all zero
    always_comb begin
        ip_total_len = q_len + 16'(IP_HDR_BYTES);
        csum_acc = 20'h04500 +
                   20'(ip_total_len) +
                   20'({REPLY_TTL, IP_PROTO_UDP}) +
                   20'(LOCAL_IP[31:16]) +
                   20'(LOCAL_IP[15:0]) +
                   20'(q_ip[31:16]) +
                   20'(q_ip[15:0]);
        // two folds are enough for seven words
        csum_fold = 20'(csum_acc[15:0]) + 20'(csum_acc[19:16]);
        csum_sum  = csum_fold[15:0] + 16'(csum_fold[19:16]);
        ip_csum   = ~csum_sum;
    end

    // reply header in wire order, byte 0 at the top
    assign hdr_next = {q_mac, LOCAL_MAC, ETHERTYPE_IPV4,
                       8'h45, 8'h00, ip_total_len, 16'h0000, 16'h0000,
                       REPLY_TTL, IP_PROTO_UDP, ip_csum, LOCAL_IP, q_ip,
                       q_dst_port, q_src_port, q_len, 16'h0000};

    always_ff @(posedge clk) begin
        if (rst) begin
            in_hdr <= 1'b0;
            in_pay <= 1'b0;
            idx    <= '0;
        end else if (q_pop) begin
            in_hdr <= 1'b1;
            idx    <= '0;
        end else if (in_hdr && out_ready) begin
            if (idx == 6'(HDR_BYTES - 1)) begin
                in_hdr <= 1'b0;
                in_pay <= 1'b1;
            end else begin
                idx <= idx + 6'd1;
            end
        end else if (in_pay && out_ready && fifo_out_valid && fifo_out_last) begin
            in_pay <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            hdr_sr <= hdr_next;
        end else if (in_hdr && out_ready) begin
            hdr_sr <= hdr_sr << 8;
        end
    end

    // payload passes straight from the FIFO
    assign out_valid      = in_hdr || (in_pay && fifo_out_valid);
    assign out_data       = in_hdr ? hdr_sr[HDR_BYTES*8-1 -: 8] : fifo_out_data;
    assign out_last       = in_pay && fifo_out_valid && fifo_out_last;
    assign fifo_out_ready = in_pay && out_ready;

endmodule

// ==== payload_fifo.sv ====
`timescale 1ns/10ps

module payload_fifo
    import udp_echo_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] fifo_in_data,
    input  logic       fifo_in_last,
    input  logic       fifo_in_valid,
    output logic       fifo_in_ready,
    output logic [7:0] fifo_out_data,
    output logic       fifo_out_last,
    output logic       fifo_out_valid,
    input  logic       fifo_out_ready
);

    logic [8:0]         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               empty;
    logic               wr_en;
    logic               rd_en;

    // depth is a power of two, so the top count bit means full
    assign full  = count[FIFO_AW];
    assign empty = count == '0;
    assign wr_en = fifo_in_valid && !full;
    assign rd_en = fifo_out_ready && !empty;

    assign fifo_in_ready  = !full;
    assign fifo_out_valid = !empty;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {fifo_in_last, fifo_in_data};
        end
    end

    // last flag rides in bit 8
    assign {fifo_out_last, fifo_out_data} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (!wr_en && rd_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== echo_filter.sv ====
`timescale 1ns/10ps

module echo_filter
    import udp_echo_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] pay_data,
    input  logic       pay_valid,
    input  logic       pay_last,
    output logic       pay_ready,
    input  logic       hdr_ok,
    input  mac_t       src_mac,
    input  ip_addr_t   src_ip,
    input  port_t      src_port,
    input  port_t      dst_port,
    input  port_t      udp_len,
    output logic [7:0] fifo_in_data,
    output logic       fifo_in_last,
    output logic       fifo_in_valid,
    input  logic       fifo_in_ready,
    output logic       q_valid,
    output mac_t       q_mac,
    output ip_addr_t   q_ip,
    output port_t      q_src_port,
    output port_t      q_dst_port,
    output port_t      q_len,
    input  logic       q_pop
);

    logic                    started;
    logic                    accept_reg;
    logic                    accept_now;
    logic                    accept;
    logic                    room;
    logic                    pay_beat;
    logic                    q_push;
    logic                    q_full;
    logic [HDR_QUEUE_AW-1:0] q_wr_ptr;
    logic [HDR_QUEUE_AW-1:0] q_rd_ptr;
    logic [HDR_QUEUE_AW:0]   q_count;

    mac_t     mac_mem  [HDR_QUEUE_DEPTH];
    ip_addr_t ip_mem   [HDR_QUEUE_DEPTH];
    port_t    sport_mem[HDR_QUEUE_DEPTH];
    port_t    dport_mem[HDR_QUEUE_DEPTH];
    port_t    len_mem  [HDR_QUEUE_DEPTH];

    assign accept_now = hdr_ok && dst_port == ECHO_PORT;
    // decision is held once the first payload byte has moved
    assign accept     = started ? accept_reg : accept_now;
    // a new frame waits for a free reply slot before its first byte
    assign room       = started || !q_full;

    assign pay_ready = accept ? (fifo_in_ready && room) : 1'b1;
    assign pay_beat  = pay_valid && pay_ready;

    assign fifo_in_data  = pay_data;
    assign fifo_in_last  = pay_last;
    assign fifo_in_valid = pay_valid && accept && room;

    always_ff @(posedge clk) begin
        if (rst) begin
            started    <= 1'b0;
            accept_reg <= 1'b0;
        end else if (pay_beat) begin
            if (pay_last) begin
                started <= 1'b0;
            end else if (!started) begin
                started    <= 1'b1;
                accept_reg <= accept_now;
            end
        end
    end

    // reply entry goes in with the last accepted byte
    assign q_push  = pay_beat && pay_last && accept;
    assign q_full  = q_count[HDR_QUEUE_AW];
    assign q_valid = q_count != '0;

    always_ff @(posedge clk) begin
        if (q_push) begin
            mac_mem[q_wr_ptr]   <= src_mac;
            ip_mem[q_wr_ptr]    <= src_ip;
            sport_mem[q_wr_ptr] <= src_port;
            dport_mem[q_wr_ptr] <= dst_port;
            len_mem[q_wr_ptr]   <= udp_len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_count  <= '0;
        end else begin
            if (q_push) begin
                q_wr_ptr <= q_wr_ptr + 1'b1;
            end
            if (q_pop && q_valid) begin
                q_rd_ptr <= q_rd_ptr + 1'b1;
            end
            if (q_push && !(q_pop && q_valid)) begin
                q_count <= q_count + 1'b1;
            end else if (!q_push && q_pop && q_valid) begin
                q_count <= q_count - 1'b1;
            end
        end
    end

    assign q_mac      = mac_mem[q_rd_ptr];
    assign q_ip       = ip_mem[q_rd_ptr];
    assign q_src_port = sport_mem[q_rd_ptr];
    assign q_dst_port = dport_mem[q_rd_ptr];
    assign q_len      = len_mem[q_rd_ptr];

endmodule

// ==== udp_rx_parser.sv ====
`timescale 1ns/10ps

module udp_rx_parser
    import udp_echo_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] in_data,
    input  logic       in_valid,
    input  logic       in_last,
    output logic       in_ready,
    output logic [7:0] pay_data,
    output logic       pay_valid,
    output logic       pay_last,
    input  logic       pay_ready,
    output logic       hdr_ok,
    output mac_t       src_mac,
    output ip_addr_t   src_ip,
    output port_t      src_port,
    output port_t      dst_port,
    output port_t      udp_len
);

    logic [5:0]  cnt;
    logic        hdr_phase;
    logic        beat;
    mac_t        dst_mac;
    logic [15:0] eth_type;
    logic [7:0]  ver_ihl;
    logic [7:0]  ip_proto;
    ip_addr_t    dst_ip;

    // counter saturates at HDR_BYTES for the rest of the frame
    assign hdr_phase = cnt < 6'(HDR_BYTES);

    // header bytes are always taken, payload follows the filter
    assign in_ready = hdr_phase || pay_ready;
    assign beat     = in_valid && in_ready;

    assign pay_data  = in_data;
    assign pay_valid = in_valid && !hdr_phase;
    assign pay_last  = in_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (beat) begin
            if (in_last) begin
                // also ends a truncated frame inside the header
                cnt <= '0;
            end else if (hdr_phase) begin
                cnt <= cnt + 6'd1;
            end
        end
    end

    // fields shift in msb first at their byte offsets
    always_ff @(posedge clk) begin
        if (beat && hdr_phase) begin
            case (cnt) inside
                [0:5]:   dst_mac  <= {dst_mac[39:0], in_data};
                [6:11]:  src_mac  <= {src_mac[39:0], in_data};
                [12:13]: eth_type <= {eth_type[7:0], in_data};
                14:      ver_ihl  <= in_data;
                23:      ip_proto <= in_data;
                [26:29]: src_ip   <= {src_ip[23:0], in_data};
                [30:33]: dst_ip   <= {dst_ip[23:0], in_data};
                [34:35]: src_port <= {src_port[7:0], in_data};
                [36:37]: dst_port <= {dst_port[7:0], in_data};
                [38:39]: udp_len  <= {udp_len[7:0], in_data};
                default: ;
            endcase
        end
    end

    // unicast to us or broadcast, plain IPv4 without options, UDP to our IP
    assign hdr_ok = (dst_mac == LOCAL_MAC || dst_mac == '1) &&
                    eth_type == ETHERTYPE_IPV4 &&
                    ver_ihl == 8'h45 &&
                    ip_proto == IP_PROTO_UDP &&
                    dst_ip == LOCAL_IP;

endmodule

// ==== udp_echo_pkg.sv ====
package udp_echo_pkg;

    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;

    // header sizes in bytes
    localparam int ETH_HDR_BYTES = 14;
    localparam int IP_HDR_BYTES  = 20;
    localparam int UDP_HDR_BYTES = 8;
    localparam int HDR_BYTES     = ETH_HDR_BYTES + IP_HDR_BYTES + UDP_HDR_BYTES;

    // protocol field values
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    localparam port_t       ECHO_PORT      = 16'd1234;
    localparam logic [7:0]  REPLY_TTL      = 8'd64;

    // node addresses
    localparam mac_t     LOCAL_MAC = 48'h11_22_33_44_55_66;
    localparam ip_addr_t LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};

    // buffer sizes, both powers of two
    localparam int FIFO_DEPTH      = 2048;
    localparam int FIFO_AW         = $clog2(FIFO_DEPTH);
    localparam int HDR_QUEUE_DEPTH = 4;
    localparam int HDR_QUEUE_AW    = $clog2(HDR_QUEUE_DEPTH);

endpackage
